//--- Makefile
# Verilator build, run, lint and clean for the MAC Merge control path

.PHONY: all lint clean

all: obj_dir/VmmsTopTb
	@out="$$(./obj_dir/VmmsTopTb)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

obj_dir/VmmsTopTb: mmsTop.f verilog/*.sv verilog/*.svh tests/*.sv
	verilator --binary --timing --assert --top-module mmsTopTb -f mmsTop.f

lint:
	verilator --lint-only --timing --top-module mmsTopTb -f mmsTop.f

clean:
	rm -rf obj_dir

//--- mmsTop.f
+incdir+verilog
verilog/mmsPkg.sv
verilog/rxSmdDecoder.sv
verilog/mergeVerify.sv
verilog/preemptControl.sv
verilog/txSmdEncoder.sv
verilog/mmsTop.sv
tests/mmsTopTb.sv

//--- tests/mmsTopTb.sv
// ----------------------------------------------------------
// Testbench for the MAC Merge control path
// Stimulus table with expected values, clock and reset,
// one compare task and bounded waits
// ----------------------------------------------------------
`include "mmsConfig_config.svh"

module mmsTopTb;

    // Row operations
    localparam int OpRx        = 0;
    localparam int OpRespond   = 1;
    localparam int OpVerifyOk  = 2;
    localparam int OpVerifyBad = 3;
    localparam int OpFrame     = 4;
    localparam int OpResume    = 5;
    localparam int OpExpress   = 6;
    localparam int OpThresh    = 7;
    // Upper bound on any wait, in cycles
    localparam int WaitLimit   = 1000;

    logic              clk;
    logic              reset_begin;
    logic              rxValid;
    logic [7:0]        rxOctet;
    logic              pStart;
    logic              pOctet;
    mmsPkg::fragSize_t pRemain;
    logic              eReq;
    logic              eStart;
    logic              pEnable;
    logic              disableVerify;
    logic              linkFail;
    logic [1:0]        addFragSize;
    logic              txSmdValid;
    logic [7:0]        txSmd;
    logic              rxKindValid;
    mmsPkg::smdKind_e  rxKind;
    mmsPkg::frameCnt_t rxFrameCnt;
    logic              preempt;
    logic              pActive;
    logic              verified;
    logic              verifyFail;

    // Stimulus table, one entry per row in each queue
    int                opQ[$];
    int                argAQ[$];
    int                argBQ[$];
    int                expQ[$];
    string             nameQ[$];
    int unsigned       seedDummy;

    mmsTop i_mmsTop
    (
        .clk(clk), .reset_begin(reset_begin),
        .rxValid(rxValid), .rxOctet(rxOctet),
        .pStart(pStart), .pOctet(pOctet), .pRemain(pRemain),
        .eReq(eReq), .eStart(eStart),
        .pEnable(pEnable), .disableVerify(disableVerify), .linkFail(linkFail),
        .addFragSize(addFragSize),
        .txSmdValid(txSmdValid), .txSmd(txSmd),
        .rxKindValid(rxKindValid), .rxKind(rxKind), .rxFrameCnt(rxFrameCnt),
        .preempt(preempt), .pActive(pActive),
        .verified(verified), .verifyFail(verifyFail)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compare(input string name, input int expected, input int actual);
        if (expected != actual)
            stopWithFailure($sformatf("Error %s: expected 0x%0h, actual 0x%0h",
                name, expected, actual));
    endtask

    task automatic idleCycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Kind in the upper bits, frame count in the lower two
    function automatic int packKind(input mmsPkg::smdKind_e kind, input int cnt);
        return int'(kind) * 4 + cnt;
    endfunction

    task automatic addRow(input int op, input int argA, input int argB, input int expVal,
                          input string name);
        opQ.push_back(op);
        argAQ.push_back(argA);
        argBQ.push_back(argB);
        expQ.push_back(expVal);
        nameQ.push_back(name);
    endtask

    task automatic setMode(input logic pEn, input logic disV);
        pEnable       = pEn;
        disableVerify = disV;
        idleCycles(3);
    endtask

    // Next SMD octet on the transmit side, any code
    task automatic waitForTx(input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!txSmdValid && cycles < WaitLimit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!txSmdValid)
            stopWithFailure({"timed out waiting for ", what, " on txSmd"});
    endtask

    task automatic runRx(input int octet, input int expVal, input string name);
        rxValid = 1'b1;
        rxOctet = 8'(octet);
        @(negedge clk);
        rxValid = 1'b0;
        compare({name, " valid"}, 1, int'(rxKindValid));
        compare({name, " kind"}, expVal / 4, int'(rxKind));
        compare({name, " count"}, expVal % 4, int'(rxFrameCnt));
    endtask

    // SMD-V in, exactly one SMD-R out at a fixed distance
    task automatic runRespond(input int expVal, input string name);
        int c;
        setMode(1'b0, 1'b0);
        rxValid = 1'b1;
        rxOctet = `MMS_SMD_V;
        for (c = 1; c <= 5; c++)
        begin
            @(negedge clk);
            rxValid = 1'b0;
            compare($sformatf("%s cycle %0d valid", name, c), (c == expVal) ? 1 : 0,
                int'(txSmdValid));
            if (c == expVal)
                compare({name, " octet"}, int'(`MMS_SMD_R), int'(txSmd));
        end
    endtask

    task automatic runVerifyOk(input int expVal, input string name);
        int cycles;
        // Start from a fresh handshake
        setMode(1'b0, 1'b0);
        pEnable = 1'b1;
        waitForTx("SMD-V");
        compare({name, " verify octet"}, int'(`MMS_SMD_V), int'(txSmd));
        rxValid = 1'b1;
        rxOctet = `MMS_SMD_R;
        @(negedge clk);
        rxValid = 1'b0;
        cycles  = 0;
        while (!verified && cycles < WaitLimit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!verified)
            stopWithFailure("timed out waiting for verified");
        compare({name, " verifyFail"}, 0, int'(verifyFail));
        compare({name, " pActive"}, expVal, int'(pActive));
    endtask

    task automatic runVerifyBad(input int expVal, input string name);
        int cycles;
        int sent;
        setMode(1'b0, 1'b0);
        pEnable = 1'b1;
        sent    = 0;
        cycles  = 0;
        // No response, count every verify attempt
        while (!verifyFail && cycles < WaitLimit)
        begin
            @(negedge clk);
            if (txSmdValid && (txSmd == `MMS_SMD_V))
                sent++;
            cycles++;
        end
        if (!verifyFail)
            stopWithFailure("timed out waiting for verifyFail");
        compare({name, " attempts"}, expVal, sent);
        compare({name, " verified"}, 0, int'(verified));
        compare({name, " pActive"}, 0, int'(pActive));
        linkFail = 1'b1;
        @(negedge clk);
        compare({name, " cleared by linkFail"}, 0, int'(verifyFail));
        pEnable = 1'b0;
        @(negedge clk);
        linkFail = 1'b0;
    endtask

    task automatic runFrame(input int expVal, input string name);
        setMode(1'b1, 1'b1);
        eReq   = 1'b0;
        pStart = 1'b1;
        @(negedge clk);
        pStart = 0;
        waitForTx("SMD-S");
        compare(name, expVal, int'(txSmd));
    endtask

    // Preempt the current frame, then end the express request
    task automatic runResume(input int expVal, input string name);
        int cycles;
        setMode(1'b1, 1'b1);
        addFragSize = 2'd0;
        pRemain     = mmsPkg::fragSize_t'(200);
        eReq        = 1'b1;
        cycles      = 0;
        while (!preempt && cycles < WaitLimit)
        begin
            pOctet = 1'b1;
            @(negedge clk);
            cycles++;
        end
        pOctet = 1'b0;
        if (!preempt)
            stopWithFailure("timed out waiting for preempt");
        eReq = 1'b0;
        waitForTx("SMD-C");
        compare(name, expVal, int'(txSmd));
    endtask

    task automatic runExpress(input int expVal, input string name);
        setMode(1'b1, 1'b1);
        eStart = 1'b1;
        @(negedge clk);
        eStart = 1'b0;
        // Encoder answers in the very next cycle
        compare({name, " valid"}, 1, int'(txSmdValid));
        compare(name, expVal, int'(txSmd));
    endtask

    // Negative threshold means preempt never rises
    task automatic runThresh(input int addFrag, input int remain, input int thresh,
                             input string name);
        int limit;
        int k;
        setMode(1'b1, 1'b1);
        addFragSize = 2'(addFrag);
        pRemain     = mmsPkg::fragSize_t'(remain);
        eReq        = 1'b1;
        pStart      = 1'b1;
        @(negedge clk);
        pStart = 1'b0;
        @(negedge clk);
        compare({name, " after start"}, 0, int'(preempt));
        limit = (thresh < 0) ? `MMS_MIN_FRAG * (1 + addFrag) + 4 : thresh + 1;
        for (k = 1; k <= limit; k++)
        begin
            pOctet = 1'b1;
            @(negedge clk);
            // Registered, so it follows the count of the cycle before
            compare($sformatf("%s octet %0d", name, k),
                (thresh >= 0 && k - 1 >= thresh) ? 1 : 0, int'(preempt));
        end
        pOctet = 1'b0;
        @(negedge clk);
        compare({name, " hold"}, (thresh >= 0) ? 1 : 0, int'(preempt));
        eReq = 1'b0;
    endtask

    task automatic buildTable();
        addRow(OpRx, int'(`MMS_PREAMBLE), 0, packKind(mmsPkg::PREAMBLE, 0), "rx preamble");
        addRow(OpRx, int'(`MMS_SMD_E), 0, packKind(mmsPkg::SMD_E, 0), "rx SMD-E");
        addRow(OpRx, int'(`MMS_SMD_V), 0, packKind(mmsPkg::SMD_V, 0), "rx SMD-V");
        addRow(OpRx, int'(`MMS_SMD_R), 0, packKind(mmsPkg::SMD_R, 0), "rx SMD-R");
        addRow(OpRx, int'(`MMS_SMD_S0), 0, packKind(mmsPkg::SMD_S, 0), "rx SMD-S0");
        addRow(OpRx, int'(`MMS_SMD_S1), 0, packKind(mmsPkg::SMD_S, 1), "rx SMD-S1");
        addRow(OpRx, int'(`MMS_SMD_S2), 0, packKind(mmsPkg::SMD_S, 2), "rx SMD-S2");
        addRow(OpRx, int'(`MMS_SMD_S3), 0, packKind(mmsPkg::SMD_S, 3), "rx SMD-S3");
        addRow(OpRx, int'(`MMS_SMD_C0), 0, packKind(mmsPkg::SMD_C, 0), "rx SMD-C0");
        addRow(OpRx, int'(`MMS_SMD_C1), 0, packKind(mmsPkg::SMD_C, 1), "rx SMD-C1");
        addRow(OpRx, int'(`MMS_SMD_C2), 0, packKind(mmsPkg::SMD_C, 2), "rx SMD-C2");
        addRow(OpRx, int'(`MMS_SMD_C3), 0, packKind(mmsPkg::SMD_C, 3), "rx SMD-C3");
        // Invalid octets, one of them a bit off SMD-E
        addRow(OpRx, 'h00, 0, packKind(mmsPkg::SMD_ERR, 0), "rx invalid 00");
        addRow(OpRx, 'hFF, 0, packKind(mmsPkg::SMD_ERR, 0), "rx invalid FF");
        addRow(OpRx, 'hD4, 0, packKind(mmsPkg::SMD_ERR, 0), "rx invalid D4");
        addRow(OpRx, 'h56, 0, packKind(mmsPkg::SMD_ERR, 0), "rx invalid 56");
        addRow(OpRespond, 0, 0, 3, "respond");
        addRow(OpVerifyOk, 0, 0, 1, "verify success");
        addRow(OpVerifyBad, 0, 0, `MMS_VERIFY_LIMIT, "verify failure");
        // Frame count rolls over after four starts
        addRow(OpFrame, 0, 0, int'(`MMS_SMD_S0), "frame 1 SMD-S");
        addRow(OpFrame, 0, 0, int'(`MMS_SMD_S1), "frame 2 SMD-S");
        addRow(OpFrame, 0, 0, int'(`MMS_SMD_S2), "frame 3 SMD-S");
        addRow(OpFrame, 0, 0, int'(`MMS_SMD_S3), "frame 4 SMD-S");
        addRow(OpFrame, 0, 0, int'(`MMS_SMD_S0), "frame 5 SMD-S");
        addRow(OpResume, 0, 0, int'(`MMS_SMD_C0), "resume SMD-C");
        addRow(OpExpress, 0, 0, int'(`MMS_SMD_E), "express SMD-E");
        // Threshold is 64 x (1 + addFragSize) - 4
        addRow(OpThresh, 0, 1000, 60, "thresh add0");
        addRow(OpThresh, 1, 1000, 124, "thresh add1");
        addRow(OpThresh, 2, 1000, 188, "thresh add2");
        addRow(OpThresh, 3, 1000, 252, "thresh add3");
        addRow(OpThresh, 0, 65, 60, "thresh remain 65");
        addRow(OpThresh, 0, 64, -1, "thresh remain 64");
        addRow(OpThresh, 2, 64, -1, "thresh remain 64 add2");
    endtask

    initial
    begin
        int row;
        seedDummy     = $urandom(37);
        reset_begin   = 1'b1;
        rxValid       = 1'b0;
        rxOctet       = 8'h00;
        pStart        = 1'b0;
        pOctet        = 1'b0;
        pRemain       = '0;
        eReq          = 1'b0;
        eStart        = 1'b0;
        pEnable       = 1'b0;
        disableVerify = 1'b0;
        linkFail      = 1'b0;
        addFragSize   = 2'd0;
        repeat (8) @(negedge clk);
        reset_begin = 1'b0;
        // Quiet outputs straight out of reset
        compare("reset txSmdValid", 0, int'(txSmdValid));
        compare("reset rxKindValid", 0, int'(rxKindValid));
        compare("reset preempt", 0, int'(preempt));
        compare("reset verified", 0, int'(verified));
        compare("reset verifyFail", 0, int'(verifyFail));
        buildTable();
        for (row = 0; row < opQ.size(); row++)
        begin
            // Random idle gap lets any earlier SMD output drain
            idleCycles(3 + int'($urandom % 4));
            case (opQ[row])
                OpRx:        runRx(argAQ[row], expQ[row], nameQ[row]);
                OpRespond:   runRespond(expQ[row], nameQ[row]);
                OpVerifyOk:  runVerifyOk(expQ[row], nameQ[row]);
                OpVerifyBad: runVerifyBad(expQ[row], nameQ[row]);
                OpFrame:     runFrame(expQ[row], nameQ[row]);
                OpResume:    runResume(expQ[row], nameQ[row]);
                OpExpress:   runExpress(expQ[row], nameQ[row]);
                default:     runThresh(argAQ[row], argBQ[row], expQ[row], nameQ[row]);
            endcase
        end
        idleCycles(4);
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- verilog/mergeVerify.sv
// ----------------------------------------------------------
// Preemption verification and respond logic
// Verify FSM with timer and attempt count, SMD-R answer,
// and the pActive level
// ----------------------------------------------------------
`include "mmsConfig_config.svh"

module mergeVerify
(
    input  logic    clk,
    input  logic    reset_begin,
    input  logic    pEnable,
    input  logic    disableVerify,
    input  logic    linkFail,
    input  logic    rcvV,
    input  logic    rcvR,
    output logic    sendV,
    output logic    sendR,
    output logic    verified,
    output logic    verifyFail,
    output logic    pActive
);

    localparam int TimerW = $clog2(`MMS_VERIFY_TIME + 1);
    localparam int CntW   = $clog2(`MMS_VERIFY_LIMIT + 1);

    mmsPkg::verifyState_e state;
    logic [TimerW-1:0]    verifyTimer;
    logic [CntW-1:0]      verifyCnt;
    logic                 abort;

    // Any of these forces the handshake back to the start
    assign abort = linkFail || !pEnable || disableVerify;

    always_ff @(posedge clk)
    begin
        sendV <= 1'b0;
        if (reset_begin || abort)
        begin
            state      <= mmsPkg::INIT_VERIFICATION;
            sendV      <= 1'b0;
            verified   <= 1'b0;
            verifyFail <= 1'b0;
            verifyCnt  <= '0;
        end
        else
        begin
            case (state)
                mmsPkg::INIT_VERIFICATION: state <= mmsPkg::VERIFICATION_IDLE;
                mmsPkg::VERIFICATION_IDLE:
                begin
                    // First attempt
                    state       <= mmsPkg::SEND_VERIFY;
                    sendV       <= 1'b1;
                    verifyCnt   <= verifyCnt + 1'b1;
                    verifyTimer <= TimerW'(`MMS_VERIFY_TIME - 1);
                end
                mmsPkg::SEND_VERIFY: state <= mmsPkg::WAIT_FOR_RESPONSE;
                mmsPkg::WAIT_FOR_RESPONSE:
                begin
                    if (rcvR)
                    begin
                        state    <= mmsPkg::VERIFIED;
                        verified <= 1'b1;
                    end
                    else if (verifyTimer != '0)
                    begin
                        verifyTimer <= verifyTimer - 1'b1;
                    end
                    else if (verifyCnt >= CntW'(`MMS_VERIFY_LIMIT))
                    begin
                        state      <= mmsPkg::VERIFY_FAIL;
                        verifyFail <= 1'b1;
                    end
                    else
                    begin
                        // Timer expired, retry
                        state       <= mmsPkg::SEND_VERIFY;
                        sendV       <= 1'b1;
                        verifyCnt   <= verifyCnt + 1'b1;
                        verifyTimer <= TimerW'(`MMS_VERIFY_TIME - 1);
                    end
                end
                // Terminal until an abort
                default: state <= state;
            endcase
        end
    end

    // Respond side answers every verify regardless of state
    always_ff @(posedge clk)
    begin
        if (reset_begin)
            sendR <= 1'b0;
        else
            sendR <= rcvV;
    end

    assign pActive = pEnable && (verified || disableVerify);

    assert property (@(posedge clk) disable iff (reset_begin) !(verified && verifyFail));

endmodule

//--- verilog/mmsConfig_config.svh
// ----------------------------------------------------------
// MAC Merge sublayer configuration constants
// Fragment sizing, verify timer and retry limit
// SMD octet encodings for express and preemptable traffic
// ----------------------------------------------------------
`ifndef MMS_CONFIG_SVH
`define MMS_CONFIG_SVH

// Minimum fragment length in octets
`define MMS_MIN_FRAG        64
// Verify timer length in clock cycles
`define MMS_VERIFY_TIME     100
// Verify attempts before giving up
`define MMS_VERIFY_LIMIT    3
// Width of octet counters
`define MMS_FRAG_W          11

// Express start, verify and respond codes
`define MMS_PREAMBLE        8'h55
`define MMS_SMD_E           8'hD5
`define MMS_SMD_V           8'h07
`define MMS_SMD_R           8'h19

// Start of preemptable frame, one code per frame count
`define MMS_SMD_S0          8'hE6
`define MMS_SMD_S1          8'h4C
`define MMS_SMD_S2          8'h7F
`define MMS_SMD_S3          8'hB3

// Continuation fragment, one code per frame count
`define MMS_SMD_C0          8'h61
`define MMS_SMD_C1          8'h52
`define MMS_SMD_C2          8'h9E
`define MMS_SMD_C3          8'h2A

`endif

//--- verilog/mmsPkg.sv
// ----------------------------------------------------------
// Shared types for the MAC Merge control path
// SMD classes, frame count, octet count, verify states
// ----------------------------------------------------------
`include "mmsConfig_config.svh"

package mmsPkg;

    // Class of one received SMD octet
    typedef enum logic [2:0]
    {
        PREAMBLE = 3'd0,
        SMD_E    = 3'd1,
        SMD_S    = 3'd2,
        SMD_C    = 3'd3,
        SMD_V    = 3'd4,
        SMD_R    = 3'd5,
        SMD_ERR  = 3'd6
    } smdKind_e;

    // Rolling count carried by SMD-S and SMD-C
    typedef logic [1:0] frameCnt_t;

    // Octet count for fragment size and remaining length
    typedef logic [`MMS_FRAG_W-1:0] fragSize_t;

    // Verification handshake states
    typedef enum logic [2:0]
    {
        INIT_VERIFICATION = 3'd0,
        VERIFICATION_IDLE = 3'd1,
        SEND_VERIFY       = 3'd2,
        WAIT_FOR_RESPONSE = 3'd3,
        VERIFIED          = 3'd4,
        VERIFY_FAIL       = 3'd5
    } verifyState_e;

endpackage

//--- verilog/mmsTop.sv
// ----------------------------------------------------------
// MAC Merge control path top level
// Receive decode, verification, preempt control, SMD encode
// ----------------------------------------------------------

module mmsTop
(
    input  logic                clk,
    input  logic                reset_begin,
    // Receive side
    input  logic                rxValid,
    input  logic [7:0]          rxOctet,
    // Preemptable frame
    input  logic                pStart,
    input  logic                pOctet,
    input  mmsPkg::fragSize_t   pRemain,
    // Express frame
    input  logic                eReq,
    input  logic                eStart,
    // Management
    input  logic                pEnable,
    input  logic                disableVerify,
    input  logic                linkFail,
    input  logic [1:0]          addFragSize,
    // Results
    output logic                txSmdValid,
    output logic [7:0]          txSmd,
    output logic                rxKindValid,
    output mmsPkg::smdKind_e    rxKind,
    output mmsPkg::frameCnt_t   rxFrameCnt,
    output logic                preempt,
    output logic                pActive,
    output logic                verified,
    output logic                verifyFail
);

    logic              rcvV, rcvR;
    logic              sendV, sendR;
    logic              startReq, resumeReq;
    mmsPkg::frameCnt_t frameCnt;

    rxSmdDecoder i_rxSmdDecoder
    (
        .clk(clk), .reset_begin(reset_begin),
        .rxValid(rxValid), .rxOctet(rxOctet),
        .rxKindValid(rxKindValid), .rxKind(rxKind), .rxFrameCnt(rxFrameCnt),
        .rcvV(rcvV), .rcvR(rcvR)
    );

    mergeVerify i_mergeVerify
    (
        .clk(clk), .reset_begin(reset_begin),
        .pEnable(pEnable), .disableVerify(disableVerify), .linkFail(linkFail),
        .rcvV(rcvV), .rcvR(rcvR),
        .sendV(sendV), .sendR(sendR),
        .verified(verified), .verifyFail(verifyFail), .pActive(pActive)
    );

    preemptControl i_preemptControl
    (
        .clk(clk), .reset_begin(reset_begin),
        .pActive(pActive), .pStart(pStart), .pOctet(pOctet), .pRemain(pRemain),
        .eReq(eReq), .addFragSize(addFragSize),
        .preempt(preempt), .startReq(startReq), .resumeReq(resumeReq),
        .frameCnt(frameCnt)
    );

    txSmdEncoder i_txSmdEncoder
    (
        .clk(clk), .reset_begin(reset_begin),
        .sendV(sendV), .sendR(sendR), .startReq(startReq), .resumeReq(resumeReq),
        .eStart(eStart), .frameCnt(frameCnt),
        .txSmdValid(txSmdValid), .txSmd(txSmd)
    );

endmodule

//--- verilog/preemptControl.sv
// ----------------------------------------------------------
// Preempt decision for the preemptable transmit path
// Fragment octet counter, rolling frame count, preempt level
// and resume request
// ----------------------------------------------------------
`include "mmsConfig_config.svh"

module preemptControl
(
    input  logic                clk,
    input  logic                reset_begin,
    input  logic                pActive,
    input  logic                pStart,
    input  logic                pOctet,
    input  mmsPkg::fragSize_t   pRemain,
    input  logic                eReq,
    input  logic [1:0]          addFragSize,
    output logic                preempt,
    output logic                startReq,
    output logic                resumeReq,
    output mmsPkg::frameCnt_t   frameCnt
);

    localparam mmsPkg::fragSize_t MinFrag = mmsPkg::fragSize_t'(`MMS_MIN_FRAG);

    mmsPkg::fragSize_t fragSize;
    mmsPkg::fragSize_t fragThresh;
    logic              firstSeen;
    logic              preemptCond;

    // minFrag x (1 + addFragSize) - 4
    assign fragThresh = mmsPkg::fragSize_t'(`MMS_MIN_FRAG * (32'(addFragSize) + 1) - 4);

    // Enough sent, enough left, and an express frame waiting
    assign preemptCond = pActive && eReq && (fragSize >= fragThresh) && (pRemain > MinFrag);

    always_ff @(posedge clk)
    begin
        if (reset_begin)
        begin
            fragSize  <= '0;
            frameCnt  <= 2'd0;
            firstSeen <= 1'b0;
            startReq  <= 1'b0;
            resumeReq <= 1'b0;
            preempt   <= 1'b0;
        end
        else
        begin
            // Count restarts with each new preemptable frame
            if (pStart)
                fragSize <= '0;
            else if (pOctet && (fragSize != '1))
                fragSize <= fragSize + 1'b1;
            // First frame keeps count 0
            if (pStart)
            begin
                firstSeen <= 1'b1;
                if (firstSeen)
                    frameCnt <= frameCnt + 1'b1;
            end
            startReq  <= pStart;
            preempt   <= preemptCond;
            // preempt already implies eReq was high last cycle
            resumeReq <= preempt && !eReq;
        end
    end

    assert property (@(posedge clk) disable iff (reset_begin) preempt |-> $past(pActive));

endmodule

//--- verilog/rxSmdDecoder.sv
// ----------------------------------------------------------
// Receive SMD decoder
// Classifies each received octet, extracts the frame count
// and flags SMD-V / SMD-R for the verify logic
// ----------------------------------------------------------
`include "mmsConfig_config.svh"

module rxSmdDecoder
(
    input  logic                clk,
    input  logic                reset_begin,
    input  logic                rxValid,
    input  logic [7:0]          rxOctet,
    output logic                rxKindValid,
    output mmsPkg::smdKind_e    rxKind,
    output mmsPkg::frameCnt_t   rxFrameCnt,
    output logic                rcvV,
    output logic                rcvR
);

    mmsPkg::smdKind_e  kindNow;
    mmsPkg::frameCnt_t cntNow;

    // Table lookup on the raw octet
    always_comb
    begin
        kindNow = mmsPkg::SMD_ERR;
        cntNow  = 2'd0;
        case (rxOctet)
            `MMS_PREAMBLE: kindNow = mmsPkg::PREAMBLE;
            `MMS_SMD_E:    kindNow = mmsPkg::SMD_E;
            `MMS_SMD_V:    kindNow = mmsPkg::SMD_V;
            `MMS_SMD_R:    kindNow = mmsPkg::SMD_R;
            // Start codes carry the frame count
            `MMS_SMD_S0: begin kindNow = mmsPkg::SMD_S; cntNow = 2'd0; end
            `MMS_SMD_S1: begin kindNow = mmsPkg::SMD_S; cntNow = 2'd1; end
            `MMS_SMD_S2: begin kindNow = mmsPkg::SMD_S; cntNow = 2'd2; end
            `MMS_SMD_S3: begin kindNow = mmsPkg::SMD_S; cntNow = 2'd3; end
            // Continuation codes as well
            `MMS_SMD_C0: begin kindNow = mmsPkg::SMD_C; cntNow = 2'd0; end
            `MMS_SMD_C1: begin kindNow = mmsPkg::SMD_C; cntNow = 2'd1; end
            `MMS_SMD_C2: begin kindNow = mmsPkg::SMD_C; cntNow = 2'd2; end
            `MMS_SMD_C3: begin kindNow = mmsPkg::SMD_C; cntNow = 2'd3; end
            default:     kindNow = mmsPkg::SMD_ERR;
        endcase
    end

    // One cycle of latency on every output
    always_ff @(posedge clk)
    begin
        if (reset_begin)
        begin
            rxKindValid <= 1'b0;
            rxKind      <= mmsPkg::PREAMBLE;
            rxFrameCnt  <= 2'd0;
            rcvV        <= 1'b0;
            rcvR        <= 1'b0;
        end
        else
        begin
            rxKindValid <= rxValid;
            // Verify handshake only sees qualified octets
            rcvV        <= rxValid && (kindNow == mmsPkg::SMD_V);
            rcvR        <= rxValid && (kindNow == mmsPkg::SMD_R);
            if (rxValid)
            begin
                rxKind     <= kindNow;
                rxFrameCnt <= cntNow;
            end
        end
    end

    // A single octet is never both verify and respond
    assert property (@(posedge clk) disable iff (reset_begin) !(rcvV && rcvR));

endmodule

//--- verilog/txSmdEncoder.sv
// ----------------------------------------------------------
// Transmit SMD encoder
// Pending flags per SMD kind, fixed priority V R S C E,
// one SMD octet per cycle
// ----------------------------------------------------------
`include "mmsConfig_config.svh"

module txSmdEncoder
(
    input  logic                clk,
    input  logic                reset_begin,
    input  logic                sendV,
    input  logic                sendR,
    input  logic                startReq,
    input  logic                resumeReq,
    input  logic                eStart,
    input  mmsPkg::frameCnt_t   frameCnt,
    output logic                txSmdValid,
    output logic [7:0]          txSmd
);

    logic              pendV, pendR, pendS, pendC, pendE;
    logic              reqV, reqR, reqS, reqC, reqE;
    logic              nxtV, nxtR, nxtS, nxtC, nxtE;
    mmsPkg::frameCnt_t heldS, heldC, cntS, cntC;
    logic [7:0]        code;

    function automatic logic [7:0] sCode(input mmsPkg::frameCnt_t cnt);
        case (cnt)
            2'd0:    return `MMS_SMD_S0;
            2'd1:    return `MMS_SMD_S1;
            2'd2:    return `MMS_SMD_S2;
            default: return `MMS_SMD_S3;
        endcase
    endfunction

    function automatic logic [7:0] cCode(input mmsPkg::frameCnt_t cnt);
        case (cnt)
            2'd0:    return `MMS_SMD_C0;
            2'd1:    return `MMS_SMD_C1;
            2'd2:    return `MMS_SMD_C2;
            default: return `MMS_SMD_C3;
        endcase
    endfunction

    function automatic logic isSCode(input logic [7:0] octet);
        return (octet == `MMS_SMD_S0) || (octet == `MMS_SMD_S1) ||
               (octet == `MMS_SMD_S2) || (octet == `MMS_SMD_S3);
    endfunction

    always_comb
    begin
        // New requests merge into pending, repeats collapse
        reqV = pendV || sendV;
        reqR = pendR || sendR;
        reqS = pendS || startReq;
        reqC = pendC || resumeReq;
        reqE = pendE || eStart;
        cntS = startReq ? frameCnt : heldS;
        cntC = resumeReq ? frameCnt : heldC;
        {nxtV, nxtR, nxtS, nxtC, nxtE} = {reqV, reqR, reqS, reqC, reqE};
        code = 8'h00;
        // Highest priority wins and leaves the pending set
        if (reqV)
        begin
            code = `MMS_SMD_V;
            nxtV = 1'b0;
        end
        else if (reqR)
        begin
            code = `MMS_SMD_R;
            nxtR = 1'b0;
        end
        else if (reqS)
        begin
            code = sCode(cntS);
            nxtS = 1'b0;
        end
        else if (reqC)
        begin
            code = cCode(cntC);
            nxtC = 1'b0;
        end
        else if (reqE)
        begin
            code = `MMS_SMD_E;
            nxtE = 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_begin)
        begin
            {pendV, pendR, pendS, pendC, pendE} <= 5'b0;
            txSmdValid <= 1'b0;
        end
        else
        begin
            {pendV, pendR, pendS, pendC, pendE} <= {nxtV, nxtR, nxtS, nxtC, nxtE};
            txSmdValid <= reqV || reqR || reqS || reqC || reqE;
        end
    end

    // Octet and held counts
    always_ff @(posedge clk)
    begin
        txSmd <= code;
        heldS <= cntS;
        heldC <= cntC;
    end

    // Back-to-back identical SMD-S needs a fresh start request
    assert property (@(posedge clk) disable iff (reset_begin)
        (txSmdValid && $past(txSmdValid) && isSCode(txSmd) && (txSmd == $past(txSmd)))
        |-> $past(startReq));

endmodule
